// ==== bench/lsu_tests.txt ====
# name op(ld/st) width(b/h/w/bu/hu) addr(hex) wdata(hex) tag(dec) exp_data(hex) exp_err(0/1)
# Stores write back zero data; addresses at 0x400 and above are unmapped
word_st_lo   st w  00000010 12345678 1  00000000 0
word_ld_lo   ld w  00000010 00000000 2  12345678 0
word_st_top  st w  000003fc 8badf00d 3  00000000 0
word_ld_top  ld w  000003fc 00000000 4  8badf00d 0
byte_base    st w  00000040 11223344 5  00000000 0
sb_off1      st b  00000041 fffffeee 6  00000000 0
sb_off3      st b  00000043 12345699 7  00000000 0
merge_b13    ld w  00000040 00000000 8  9922ee44 0
sb_off0      st b  00000040 0000007f 9  00000000 0
sb_off2      st b  00000042 00000080 10 00000000 0
merge_b02    ld w  00000040 00000000 11 9980ee7f 0
half_base    st w  00000050 cafef00d 12 00000000 0
sh_off0      st h  00000050 abcd1234 13 00000000 0
merge_h0     ld w  00000050 00000000 14 cafe1234 0
sh_off2      st h  00000052 00008765 15 00000000 0
merge_h2     ld w  00000050 00000000 16 87651234 0
lb_off0      ld b  00000040 00000000 17 0000007f 0
lb_off1      ld b  00000041 00000000 18 ffffffee 0
lb_off2      ld b  00000042 00000000 19 ffffff80 0
lb_off3      ld b  00000043 00000000 20 ffffff99 0
lbu_off0     ld bu 00000040 00000000 21 0000007f 0
lbu_off1     ld bu 00000041 00000000 22 000000ee 0
lbu_off2     ld bu 00000042 00000000 23 00000080 0
lbu_off3     ld bu 00000043 00000000 24 00000099 0
lh_off0      ld h  00000050 00000000 25 00001234 0
lh_off2      ld h  00000052 00000000 26 ffff8765 0
lhu_off0     ld hu 00000040 00000000 27 0000ee7f 0
lhu_off2     ld hu 00000052 00000000 28 00008765 0
err_st_w     st w  00001010 deadbeef 29 00000000 1
err_st_b     st b  00000400 000000ff 30 00000000 1
err_ld_w     ld w  00001010 00000000 31 00000000 1
err_ld_hu    ld hu 00000402 00000000 0  00000000 1
keep_w10     ld w  00000010 00000000 1  12345678 0
keep_w00     ld w  00000000 00000000 2  00000000 0
burst_st     st h  00000082 0000beef 3  00000000 0
burst_ld     ld w  00000080 00000000 4  beef0000 0
burst_lhu    ld hu 00000082 00000000 5  0000beef 0

// ==== vlog.f ====
src/cb_pkg.sv
src/lsu_pkg.sv
src/lsu_addr_stage.sv
src/lsu_data_stage.sv
src/lsu_load_align.sv
src/data_mem.sv
src/lsu_top.sv
bench/tb_lsu_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the load/store testbench with Verilator, runs it
# and decides pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_lsu_top -f vlog.f -o sim_lsu_top > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  cat build.log
  exit 1
fi

./obj_dir/sim_lsu_top > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see sim.log"
  cat sim.log
  exit 1
fi

cat sim.log

grep -q "TEST FAILED" sim.log
if [ $? -eq 0 ]; then
  echo "Simulation reported failures"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

// ==== bench/tb_lsu_top.sv ====
// ****************************************
// Testbench for the load/store path. Reads one
// operation per line from bench/lsu_tests.txt,
// issues it under memory stalls and idle gaps,
// and checks each write-back in issue order.
// ****************************************
module tb_lsu_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 200;
  localparam int TW         = lsu_pkg::TAG_W;

  logic                clk;
  logic                rst_n_i;
  lsu_pkg::lsu_op_e    lsu_op_i;
  lsu_pkg::lsu_width_e lsu_width_i;
  logic [31:0]         lsu_addr_i;
  logic [31:0]         lsu_wdata_i;
  logic [TW-1:0]       lsu_tag_i;
  logic                lsu_bp_o;
  logic                wb_valid_o;
  logic                wb_load_o;
  logic [TW-1:0]       wb_tag_o;
  logic [31:0]         wb_data_o;
  logic                wb_error_o;

  // Expected write-back results in issue order
  string               exp_name_q[$];
  logic [TW-1:0]       exp_tag_q[$];
  logic                exp_load_q[$];
  logic [31:0]         exp_data_q[$];
  logic                exp_err_q[$];

  int                  value_errors;
  int                  timeout_errors;
  int                  other_errors;
  int                  checked;
  int                  seed;

  lsu_top #(
    .MEM_ADDR_W (8),
    .STALL_EN   (1'b1)
  ) dut (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .lsu_op_i    (lsu_op_i),
    .lsu_width_i (lsu_width_i),
    .lsu_addr_i  (lsu_addr_i),
    .lsu_wdata_i (lsu_wdata_i),
    .lsu_tag_i   (lsu_tag_i),
    .lsu_bp_o    (lsu_bp_o),
    .wb_valid_o  (wb_valid_o),
    .wb_load_o   (wb_load_o),
    .wb_tag_o    (wb_tag_o),
    .wb_data_o   (wb_data_o),
    .wb_error_o  (wb_error_o)
  );

  always #20 clk = ~clk;

  function automatic bit op_from_text(input string txt, output lsu_pkg::lsu_op_e op);
    op = lsu_pkg::NO_LSU;
    if (txt == "ld") begin
      op = lsu_pkg::LSU_LOAD;
    end else if (txt == "st") begin
      op = lsu_pkg::LSU_STORE;
    end
    return (op != lsu_pkg::NO_LSU);
  endfunction

  function automatic bit width_from_text(input string txt, output lsu_pkg::lsu_width_e width);
    bit known;
    known = 1'b1;
    width = lsu_pkg::RV_LSU_W;
    if (txt == "b") begin
      width = lsu_pkg::RV_LSU_B;
    end else if (txt == "h") begin
      width = lsu_pkg::RV_LSU_H;
    end else if (txt == "bu") begin
      width = lsu_pkg::RV_LSU_BU;
    end else if (txt == "hu") begin
      width = lsu_pkg::RV_LSU_HU;
    end else if (txt != "w") begin
      known = 1'b0;
    end
    return known;
  endfunction

  // Compares one write-back against the oldest expectation
  task automatic check_result();
    string         name;
    logic [TW-1:0] tag;
    logic          is_load;
    logic [31:0]   data;
    logic          err;
    if (exp_tag_q.size() == 0) begin
      other_errors++;
      $display("Write-back with tag %0d came with no operation outstanding", wb_tag_o);
    end else begin
      name    = exp_name_q.pop_front();
      tag     = exp_tag_q.pop_front();
      is_load = exp_load_q.pop_front();
      data    = exp_data_q.pop_front();
      err     = exp_err_q.pop_front();
      checked++;
      if (wb_tag_o !== tag) begin
        value_errors++;
        $display("FAILED %s tag: expected %0d, actual %0d", name, tag, wb_tag_o);
      end
      if (wb_load_o !== is_load) begin
        value_errors++;
        $display("FAILED %s load flag: expected %0b, actual %0b", name, is_load, wb_load_o);
      end
      if (wb_data_o !== data) begin
        value_errors++;
        $display("FAILED %s data: expected %h, actual %h", name, data, wb_data_o);
      end
      if (wb_error_o !== err) begin
        value_errors++;
        $display("FAILED %s error: expected %0b, actual %0b", name, err, wb_error_o);
      end
    end
  endtask

  always @(negedge clk) begin
    if (rst_n_i && wb_valid_o) begin
      check_result();
    end
  end

  // Starts on a rising edge and returns on the next one after the wait
  task automatic issue_op(input string name, input lsu_pkg::lsu_op_e op,
                          input lsu_pkg::lsu_width_e width, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [TW-1:0] tag,
                          input logic [31:0] exp_data, input logic exp_err,
                          output bit accepted);
    int waited;
    waited = 0;
    lsu_op_i    <= op;
    lsu_width_i <= width;
    lsu_addr_i  <= addr;
    lsu_wdata_i <= wdata;
    lsu_tag_i   <= tag;
    @(negedge clk);
    while (lsu_bp_o && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (lsu_bp_o) begin
      accepted = 1'b0;
      timeout_errors++;
      $display("Operation %s was not accepted within %0d cycles", name, WAIT_LIMIT);
    end else begin
      accepted = 1'b1;
      exp_name_q.push_back(name);
      exp_tag_q.push_back(tag);
      exp_load_q.push_back(op == lsu_pkg::LSU_LOAD);
      exp_data_q.push_back(exp_data);
      exp_err_q.push_back(exp_err);
    end
    @(posedge clk);
  endtask

  task automatic insert_idle_gap();
    int gap;
    gap = $unsigned($random(seed)) % 4;
    if (gap > 0) begin
      lsu_op_i <= lsu_pkg::NO_LSU;
      repeat (gap) @(posedge clk);
    end
  endtask

  task automatic run_test_file();
    int                  fd;
    int                  code;
    int                  tag_val;
    int                  err_val;
    bit                  at_end;
    bit                  accepted;
    bit                  op_ok;
    bit                  width_ok;
    string               name;
    string               op_txt;
    string               width_txt;
    logic [31:0]         addr;
    logic [31:0]         wdata;
    logic [31:0]         exp_data;
    logic [2047:0]       rest_of_line;
    lsu_pkg::lsu_op_e    op;
    lsu_pkg::lsu_width_e width;
    fd = $fopen("bench/lsu_tests.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Cannot open the test file bench/lsu_tests.txt");
    end else begin
      at_end = 1'b0;
      while (!at_end) begin
        code = $fscanf(fd, "%s", name);
        if (code != 1) begin
          at_end = 1'b1;
        end else if (name.getc(0) == "#") begin
          code = $fgets(rest_of_line, fd);
        end else begin
          code = $fscanf(fd, "%s %s %h %h %d %h %d", op_txt, width_txt, addr, wdata,
                         tag_val, exp_data, err_val);
          op_ok    = op_from_text(op_txt, op);
          width_ok = width_from_text(width_txt, width);
          if (code != 7) begin
            other_errors++;
            $display("Test line %s is incomplete", name);
            at_end = 1'b1;
          end else if (!op_ok || !width_ok) begin
            other_errors++;
            $display("Test line %s has an unknown op or width", name);
          end else begin
            issue_op(name, op, width, addr, wdata, tag_val[TW-1:0], exp_data, err_val[0],
                     accepted);
            if (accepted) begin
              insert_idle_gap();
            end else begin
              at_end = 1'b1;
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    lsu_op_i <= lsu_pkg::NO_LSU;
    while (exp_tag_q.size() != 0 && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_tag_q.size() != 0) begin
      timeout_errors++;
      $display("%0d results still missing after %0d cycles", exp_tag_q.size(), WAIT_LIMIT);
    end
    // A few more cycles to catch stray write-backs
    repeat (4) @(negedge clk);
  endtask

  initial begin
    clk            = 1'b0;
    rst_n_i        = 1'b0;
    lsu_op_i       = lsu_pkg::NO_LSU;
    lsu_width_i    = lsu_pkg::RV_LSU_W;
    lsu_addr_i     = '0;
    lsu_wdata_i    = '0;
    lsu_tag_i      = '0;
    value_errors   = 0;
    timeout_errors = 0;
    other_errors   = 0;
    checked        = 0;
    seed           = 68467;
    repeat (16) @(posedge clk);
    rst_n_i <= 1'b1;
    @(posedge clk);
    run_test_file();
    wait_for_drain();
    if (checked == 0) begin
      other_errors++;
      $display("No write-back results were checked");
    end
    $display("Results checked %0d, value errors %0d, timeouts %0d, other errors %0d",
             checked, value_errors, timeout_errors, other_errors);
    if (value_errors + timeout_errors + other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== src/lsu_top.sv ====
// ****************************************
// Load/store path top. Address stage, data stage
// and write-back align around the core bus memory.
// MEM_ADDR_W and STALL_EN go to the memory.
// ****************************************
module lsu_top #(
  parameter int MEM_ADDR_W = 8,
  parameter bit STALL_EN   = 1'b0
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  lsu_pkg::lsu_op_e           lsu_op_i,
  input  lsu_pkg::lsu_width_e        lsu_width_i,
  input  logic [31:0]                lsu_addr_i,
  input  logic [31:0]                lsu_wdata_i,
  input  logic [lsu_pkg::TAG_W-1:0]  lsu_tag_i,
  output logic                       lsu_bp_o,
  output logic                       wb_valid_o,
  output logic                       wb_load_o,
  output logic [lsu_pkg::TAG_W-1:0]  wb_tag_o,
  output logic [31:0]                wb_data_o,
  output logic                       wb_error_o
);

  // Core bus
  logic [31:0]                  rd_addr;
  logic                         rd_addr_valid;
  logic                         rd_addr_ready;
  logic                         rd_valid;
  logic                         rd_ready;
  logic [cb_pkg::CB_DATA_W-1:0] rd_data;
  cb_pkg::cb_resp_e             rd_resp;
  logic [31:0]                  wr_addr;
  logic                         wr_addr_valid;
  logic                         wr_addr_ready;
  logic [cb_pkg::CB_DATA_W-1:0] wr_data;
  logic [cb_pkg::CB_STRB_W-1:0] wr_strobe;
  logic                         wr_data_valid;
  logic                         wr_data_ready;
  logic                         wr_resp_valid;
  cb_pkg::cb_resp_e             wr_resp;

  // Between stages
  logic                         data_stall;
  lsu_pkg::lsu_op_e             dp_op;
  lsu_pkg::lsu_width_e          dp_width;
  logic [1:0]                   dp_offset;
  logic [31:0]                  dp_wdata;
  logic [lsu_pkg::TAG_W-1:0]    dp_tag;
  logic                         done;
  logic                         done_load;
  lsu_pkg::lsu_width_e          done_width;
  logic [1:0]                   done_offset;
  logic [lsu_pkg::TAG_W-1:0]    done_tag;
  logic [31:0]                  done_rdata;
  logic                         done_error;

  // Size is always a full word, the memory does not decode it
  lsu_addr_stage u_addr_stage (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .lsu_op_i        (lsu_op_i),
    .lsu_width_i     (lsu_width_i),
    .lsu_addr_i      (lsu_addr_i),
    .lsu_wdata_i     (lsu_wdata_i),
    .lsu_tag_i       (lsu_tag_i),
    .rd_addr_ready_i (rd_addr_ready),
    .wr_addr_ready_i (wr_addr_ready),
    .data_stall_i    (data_stall),
    .lsu_bp_o        (lsu_bp_o),
    .rd_addr_o       (rd_addr),
    .rd_addr_valid_o (rd_addr_valid),
    .wr_addr_o       (wr_addr),
    .wr_addr_valid_o (wr_addr_valid),
    .addr_size_o     (),
    .dp_op_o         (dp_op),
    .dp_width_o      (dp_width),
    .dp_offset_o     (dp_offset),
    .dp_wdata_o      (dp_wdata),
    .dp_tag_o        (dp_tag)
  );

  lsu_data_stage u_data_stage (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .dp_op_i         (dp_op),
    .dp_width_i      (dp_width),
    .dp_offset_i     (dp_offset),
    .dp_wdata_i      (dp_wdata),
    .dp_tag_i        (dp_tag),
    .wr_data_ready_i (wr_data_ready),
    .rd_valid_i      (rd_valid),
    .rd_data_i       (rd_data),
    .rd_resp_i       (rd_resp),
    .wr_resp_valid_i (wr_resp_valid),
    .wr_resp_i       (wr_resp),
    .data_stall_o    (data_stall),
    .wr_data_o       (wr_data),
    .wr_strobe_o     (wr_strobe),
    .wr_data_valid_o (wr_data_valid),
    .rd_ready_o      (rd_ready),
    .done_o          (done),
    .done_load_o     (done_load),
    .done_width_o    (done_width),
    .done_offset_o   (done_offset),
    .done_tag_o      (done_tag),
    .done_rdata_o    (done_rdata),
    .done_error_o    (done_error)
  );

  lsu_load_align u_load_align (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .done_i        (done),
    .done_load_i   (done_load),
    .done_width_i  (done_width),
    .done_offset_i (done_offset),
    .done_tag_i    (done_tag),
    .done_rdata_i  (done_rdata),
    .done_error_i  (done_error),
    .wb_valid_o    (wb_valid_o),
    .wb_load_o     (wb_load_o),
    .wb_tag_o      (wb_tag_o),
    .wb_data_o     (wb_data_o),
    .wb_error_o    (wb_error_o)
  );

  data_mem #(
    .MEM_ADDR_W (MEM_ADDR_W),
    .STALL_EN   (STALL_EN)
  ) u_data_mem (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .rd_addr_i       (rd_addr),
    .rd_addr_valid_i (rd_addr_valid),
    .rd_ready_i      (rd_ready),
    .wr_addr_i       (wr_addr),
    .wr_addr_valid_i (wr_addr_valid),
    .wr_data_i       (wr_data),
    .wr_strobe_i     (wr_strobe),
    .wr_data_valid_i (wr_data_valid),
    .rd_addr_ready_o (rd_addr_ready),
    .wr_addr_ready_o (wr_addr_ready),
    .rd_valid_o      (rd_valid),
    .rd_data_o       (rd_data),
    .rd_resp_o       (rd_resp),
    .wr_data_ready_o (wr_data_ready),
    .wr_resp_valid_o (wr_resp_valid),
    .wr_resp_o       (wr_resp)
  );

endmodule

// ==== src/data_mem.sv ====
// ****************************************
// Word memory slave on the core bus. Latches one
// read and one write address, serves the data beat
// the cycle after and flags unmapped addresses
// with SLVERR. STALL_EN adds random ready gaps.
// ****************************************
module data_mem #(
  parameter int MEM_ADDR_W = 8,
  parameter bit STALL_EN   = 1'b0
) (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic [31:0]                   rd_addr_i,
  input  logic                          rd_addr_valid_i,
  input  logic                          rd_ready_i,
  input  logic [31:0]                   wr_addr_i,
  input  logic                          wr_addr_valid_i,
  input  logic [cb_pkg::CB_DATA_W-1:0]  wr_data_i,
  input  logic [cb_pkg::CB_STRB_W-1:0]  wr_strobe_i,
  input  logic                          wr_data_valid_i,
  output logic                          rd_addr_ready_o,
  output logic                          wr_addr_ready_o,
  output logic                          rd_valid_o,
  output logic [cb_pkg::CB_DATA_W-1:0]  rd_data_o,
  output cb_pkg::cb_resp_e              rd_resp_o,
  output logic                          wr_data_ready_o,
  output logic                          wr_resp_valid_o,
  output cb_pkg::cb_resp_e              wr_resp_o
);

  localparam int DEPTH = 2 ** MEM_ADDR_W;

  logic [cb_pkg::CB_DATA_W-1:0] mem [DEPTH];
  logic [15:0]                  lfsr_q;
  logic                         up_q;
  logic                         addr_gap;
  logic                         data_gap;
  logic                         rd_pend_q;
  logic                         rd_err_q;
  logic [MEM_ADDR_W-1:0]        rd_idx_q;
  logic                         wr_pend_q;
  logic                         wr_err_q;
  logic [MEM_ADDR_W-1:0]        wr_idx_q;
  logic                         rd_fire;
  logic                         wr_fire;

  // Roughly one cycle in four is a gap on each side
  assign addr_gap = STALL_EN && lfsr_q[0] && lfsr_q[5];
  assign data_gap = STALL_EN && lfsr_q[2] && lfsr_q[9];

  assign rd_valid_o      = rd_pend_q && !data_gap;
  assign rd_fire         = rd_valid_o && rd_ready_i;
  assign rd_data_o       = rd_err_q ? '0 : mem[rd_idx_q];
  assign rd_resp_o       = rd_err_q ? cb_pkg::CB_SLVERR : cb_pkg::CB_OKAY;
  assign rd_addr_ready_o = up_q && !addr_gap && (!rd_pend_q || rd_fire);

  assign wr_data_ready_o = wr_pend_q && !data_gap;
  assign wr_fire         = wr_data_ready_o && wr_data_valid_i;
  assign wr_resp_valid_o = wr_fire;
  assign wr_resp_o       = wr_err_q ? cb_pkg::CB_SLVERR : cb_pkg::CB_OKAY;
  assign wr_addr_ready_o = up_q && !addr_gap && (!wr_pend_q || wr_fire);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lfsr_q    <= 16'hace1;
      up_q      <= 1'b0;
      rd_pend_q <= 1'b0;
      wr_pend_q <= 1'b0;
    end else begin
      lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      up_q   <= 1'b1;
      if (rd_addr_valid_i && rd_addr_ready_o) begin
        rd_pend_q <= 1'b1;
      end else if (rd_fire) begin
        rd_pend_q <= 1'b0;
      end
      if (wr_addr_valid_i && wr_addr_ready_o) begin
        wr_pend_q <= 1'b1;
      end else if (wr_fire) begin
        wr_pend_q <= 1'b0;
      end
    end
  end

  // Anything set above the mapped word range is unmapped
  always_ff @(posedge clk) begin
    if (rd_addr_valid_i && rd_addr_ready_o) begin
      rd_idx_q <= rd_addr_i[MEM_ADDR_W+1:2];
      rd_err_q <= |rd_addr_i[31:MEM_ADDR_W+2];
    end
    if (wr_addr_valid_i && wr_addr_ready_o) begin
      wr_idx_q <= wr_addr_i[MEM_ADDR_W+1:2];
      wr_err_q <= |wr_addr_i[31:MEM_ADDR_W+2];
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_fire && !wr_err_q) begin
      for (int i = 0; i < cb_pkg::CB_STRB_W; i++) begin
        if (wr_strobe_i[i]) begin
          mem[wr_idx_q][i*8 +: 8] <= wr_data_i[i*8 +: 8];
        end
      end
    end
  end

endmodule

// ==== src/lsu_load_align.sv ====
// ****************************************
// Write-back stage. Picks the addressed byte or
// halfword of a load, extends it by width and
// registers the result with a one-cycle valid.
// Stores and failed loads write back zero.
// ****************************************
module lsu_load_align (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       done_i,
  input  logic                       done_load_i,
  input  lsu_pkg::lsu_width_e        done_width_i,
  input  logic [1:0]                 done_offset_i,
  input  logic [lsu_pkg::TAG_W-1:0]  done_tag_i,
  input  logic [31:0]                done_rdata_i,
  input  logic                       done_error_i,
  output logic                       wb_valid_o,
  output logic                       wb_load_o,
  output logic [lsu_pkg::TAG_W-1:0]  wb_tag_o,
  output logic [31:0]                wb_data_o,
  output logic                       wb_error_o
);

  lsu_pkg::lane_word_u lanes;
  logic [7:0]          sel_b;
  logic [15:0]         sel_h;
  logic [31:0]         ext_data;

  assign lanes = lsu_pkg::lane_word_u'(done_rdata_i);
  assign sel_b = lanes.byte_lane[done_offset_i];
  assign sel_h = lanes.half_lane[done_offset_i[1]];

  always_comb begin
    case (done_width_i)
      lsu_pkg::RV_LSU_B:  ext_data = {{24{sel_b[7]}}, sel_b};
      lsu_pkg::RV_LSU_BU: ext_data = {24'h0, sel_b};
      lsu_pkg::RV_LSU_H:  ext_data = {{16{sel_h[15]}}, sel_h};
      lsu_pkg::RV_LSU_HU: ext_data = {16'h0, sel_h};
      default:            ext_data = done_rdata_i;
    endcase
    if (!done_load_i || done_error_i) begin
      ext_data = 32'h0;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= done_i;
    end
  end

  always_ff @(posedge clk) begin
    if (done_i) begin
      wb_load_o  <= done_load_i;
      wb_tag_o   <= done_tag_i;
      wb_data_o  <= ext_data;
      wb_error_o <= done_error_i;
    end
  end

endmodule

// ==== src/lsu_data_stage.sv ====
// ****************************************
// Data phase of the load/store unit. Shifts store
// data and strobes into their lanes, stalls the
// address phase until the ending beat and captures
// the outcome with its bus error for write-back.
// ****************************************
module lsu_data_stage (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  lsu_pkg::lsu_op_e              dp_op_i,
  input  lsu_pkg::lsu_width_e           dp_width_i,
  input  logic [1:0]                    dp_offset_i,
  input  logic [31:0]                   dp_wdata_i,
  input  logic [lsu_pkg::TAG_W-1:0]     dp_tag_i,
  input  logic                          wr_data_ready_i,
  input  logic                          rd_valid_i,
  input  logic [cb_pkg::CB_DATA_W-1:0]  rd_data_i,
  input  cb_pkg::cb_resp_e              rd_resp_i,
  input  logic                          wr_resp_valid_i,
  input  cb_pkg::cb_resp_e              wr_resp_i,
  output logic                          data_stall_o,
  output logic [cb_pkg::CB_DATA_W-1:0]  wr_data_o,
  output logic [cb_pkg::CB_STRB_W-1:0]  wr_strobe_o,
  output logic                          wr_data_valid_o,
  output logic                          rd_ready_o,
  output logic                          done_o,
  output logic                          done_load_o,
  output lsu_pkg::lsu_width_e           done_width_o,
  output logic [1:0]                    done_offset_o,
  output logic [lsu_pkg::TAG_W-1:0]     done_tag_o,
  output logic [31:0]                   done_rdata_o,
  output logic                          done_error_o
);

  logic                         is_load;
  logic                         is_store;
  logic                         beat;
  logic                         beat_err;
  logic [cb_pkg::CB_STRB_W-1:0] base_strb;
  lsu_pkg::lane_word_u          lanes;

  assign is_load  = (dp_op_i == lsu_pkg::LSU_LOAD);
  assign is_store = (dp_op_i == lsu_pkg::LSU_STORE);

  // Store lanes, data replicated then masked by the strobes
  always_comb begin
    case (dp_width_i)
      lsu_pkg::RV_LSU_B, lsu_pkg::RV_LSU_BU: begin
        base_strb       = 4'b0001;
        lanes.byte_lane = {4{dp_wdata_i[7:0]}};
      end
      lsu_pkg::RV_LSU_H, lsu_pkg::RV_LSU_HU: begin
        base_strb       = 4'b0011;
        lanes.half_lane = {2{dp_wdata_i[15:0]}};
      end
      default: begin
        base_strb = 4'b1111;
        lanes     = lsu_pkg::lane_word_u'(dp_wdata_i);
      end
    endcase
    wr_strobe_o = base_strb << dp_offset_i;
    for (int i = 0; i < cb_pkg::CB_STRB_W; i++) begin
      if (!wr_strobe_o[i]) begin
        lanes.byte_lane[i] = 8'h00;
      end
    end
  end

  assign wr_data_o       = lanes;
  assign wr_data_valid_o = is_store;
  assign rd_ready_o      = 1'b1;

  // Ending beat of the phase, response comes with it
  assign beat         = (is_store && wr_data_ready_i) || (is_load && rd_valid_i);
  assign data_stall_o = (is_store && !wr_data_ready_i) || (is_load && !rd_valid_i);
  assign beat_err     = is_store ? (wr_resp_valid_i && (wr_resp_i != cb_pkg::CB_OKAY))
                                 : (rd_resp_i != cb_pkg::CB_OKAY);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_o       <= 1'b0;
      done_load_o  <= 1'b0;
      done_error_o <= 1'b0;
    end else begin
      done_o <= beat;
      if (beat) begin
        done_load_o  <= is_load;
        done_error_o <= beat_err;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat) begin
      done_width_o  <= dp_width_i;
      done_offset_o <= dp_offset_i;
      done_tag_o    <= dp_tag_i;
      done_rdata_o  <= rd_data_i;
    end
  end

endmodule

// ==== src/lsu_addr_stage.sv ====
// ****************************************
// Address phase of the load/store unit. Drives the
// word-aligned read or write address channel for
// the presented operation, raises back-pressure to
// execute and loads the data phase register.
// ****************************************
module lsu_addr_stage (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  lsu_pkg::lsu_op_e              lsu_op_i,
  input  lsu_pkg::lsu_width_e           lsu_width_i,
  input  logic [31:0]                   lsu_addr_i,
  input  logic [31:0]                   lsu_wdata_i,
  input  logic [lsu_pkg::TAG_W-1:0]     lsu_tag_i,
  input  logic                          rd_addr_ready_i,
  input  logic                          wr_addr_ready_i,
  input  logic                          data_stall_i,
  output logic                          lsu_bp_o,
  output logic [31:0]                   rd_addr_o,
  output logic                          rd_addr_valid_o,
  output logic [31:0]                   wr_addr_o,
  output logic                          wr_addr_valid_o,
  output cb_pkg::cb_size_e              addr_size_o,
  output lsu_pkg::lsu_op_e              dp_op_o,
  output lsu_pkg::lsu_width_e           dp_width_o,
  output logic [1:0]                    dp_offset_o,
  output logic [31:0]                   dp_wdata_o,
  output logic [lsu_pkg::TAG_W-1:0]     dp_tag_o
);

  logic is_load;
  logic is_store;
  logic bp_addr;

  assign is_load  = (lsu_op_i == lsu_pkg::LSU_LOAD);
  assign is_store = (lsu_op_i == lsu_pkg::LSU_STORE);

  // Address not taken this cycle
  assign bp_addr  = (is_load && !rd_addr_ready_i) || (is_store && !wr_addr_ready_i);
  assign lsu_bp_o = bp_addr || data_stall_i;

  // Byte selection is done with strobes, so the bus only sees words
  assign rd_addr_o       = {lsu_addr_i[31:2], 2'b00};
  assign wr_addr_o       = {lsu_addr_i[31:2], 2'b00};
  assign rd_addr_valid_o = is_load && !data_stall_i;
  assign wr_addr_valid_o = is_store && !data_stall_i;
  assign addr_size_o     = cb_pkg::CB_WORD;

  // NO_LSU here means the data phase is empty
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dp_op_o <= lsu_pkg::NO_LSU;
    end else if (!lsu_bp_o) begin
      dp_op_o <= lsu_op_i;
    end else if (!data_stall_i) begin
      // Data phase ended while the next address waits
      dp_op_o <= lsu_pkg::NO_LSU;
    end
  end

  always_ff @(posedge clk) begin
    if (!lsu_bp_o) begin
      dp_width_o  <= lsu_width_i;
      dp_offset_o <= lsu_addr_i[1:0];
      dp_wdata_o  <= lsu_wdata_i;
      dp_tag_o    <= lsu_tag_i;
    end
  end

endmodule

// ==== src/lsu_pkg.sv ====
// ****************************************
// Load/store unit definitions. Operation kind and
// access width as decoded by execute, the lane
// view of a bus word and the write-back tag width.
// ****************************************
package lsu_pkg;

  typedef enum logic [1:0] {
    NO_LSU    = 2'b00,
    LSU_LOAD  = 2'b01,
    LSU_STORE = 2'b10
  } lsu_op_e;

  // Codes follow the RV32 funct3 field of loads and stores
  typedef enum logic [2:0] {
    RV_LSU_B  = 3'b000,
    RV_LSU_H  = 3'b001,
    RV_LSU_W  = 3'b010,
    RV_LSU_BU = 3'b100,
    RV_LSU_HU = 3'b101
  } lsu_width_e;

  // One bus word, seen as byte lanes or as halfword lanes
  typedef union packed {
    logic [3:0][7:0]  byte_lane;
    logic [1:0][15:0] half_lane;
  } lane_word_u;

  // Destination register tag carried to write-back
  localparam int TAG_W = 5;

endpackage

// ==== src/cb_pkg.sv ====
// ****************************************
// Core bus definitions shared by the load/store
// unit and the data memory slave. Covers the
// transfer size, the response code and the
// widths of the data and strobe lanes.
// ****************************************
package cb_pkg;

  // Transfer size on the address channel
  typedef enum logic [1:0] {
    CB_BYTE      = 2'b00,
    CB_HALF_WORD = 2'b01,
    CB_WORD      = 2'b10
  } cb_size_e;

  // Response code, same encoding as the AXI resp field
  typedef enum logic [1:0] {
    CB_OKAY   = 2'b00,
    CB_SLVERR = 2'b10
  } cb_resp_e;

  localparam int CB_DATA_W = 32;
  localparam int CB_STRB_W = CB_DATA_W / 8;

endpackage
